/* periph_pkg.sv */
`default_nettype none

package periph_pkg;

    // register address as seen on the processor port.
    typedef logic [3:0] reg_addr_t;

    localparam int NUM_REGS = 10;

    // register map, DR_ is read/write and SR_ is read only.
    localparam reg_addr_t DR_LEDS           = 4'd0;
    localparam reg_addr_t SR_KEYS           = 4'd1;
    localparam reg_addr_t DR_ANMUX_CTRL     = 4'd2;
    localparam reg_addr_t DR_USTIMER0       = 4'd3;
    localparam reg_addr_t DR_MSTIMER0       = 4'd4;
    localparam reg_addr_t DR_MSTIMER1       = 4'd5;
    localparam reg_addr_t DR_POWER_DUTY     = 4'd6;
    localparam reg_addr_t DR_SOFT_EVENT     = 4'd7;
    localparam reg_addr_t SR_EVENT_PRIORITY = 4'd8;
    localparam reg_addr_t DR_EVENT_ENABLE   = 4'd9;

    // tick divisors, 50 MHz sysclk.
    localparam int SYSCLK_PER_US  = 50;
    localparam int US_PER_MS      = 1000;
    localparam int US_COUNT_WIDTH = $clog2(SYSCLK_PER_US);
    localparam int MS_COUNT_WIDTH = $clog2(US_PER_MS);
    typedef logic [US_COUNT_WIDTH-1:0] us_count_t;
    typedef logic [MS_COUNT_WIDTH-1:0] ms_count_t;

    // relay pwm, 50 us period gives 20 kHz.
    localparam int PWM_PERIOD      = 50;
    localparam int PWM_DUTY_WIDTH  = 6;
    localparam int PWM_PHASE_WIDTH = $clog2(PWM_PERIOD);
    typedef logic [PWM_PHASE_WIDTH-1:0] pwm_phase_t;
    typedef logic [PWM_DUTY_WIDTH-1:0] pwm_duty_t;

    // event indices, most urgent first.
    localparam int NUM_EVENTS     = 13;
    localparam int EV_INDEX_WIDTH = $clog2(NUM_EVENTS + 1);
    typedef logic [EV_INDEX_WIDTH-1:0] ev_index_t;
    localparam int EV_ZERO       = 0;
    localparam int EV_POWER_LOST = 1;
    localparam int EV_USTIMER0   = 2;
    localparam int EV_MSTIMER0   = 3;
    localparam int EV_MSTIMER1   = 4;
    localparam int EV_KEY0       = 5;
    localparam int EV_KEY1       = 6;
    localparam int EV_IGN_OFF    = 7;
    localparam int EV_IGN_ON     = 8;
    localparam int EV_SOFT0      = 9;
    localparam int EV_SOFT1      = 10;
    localparam int EV_SOFT2      = 11;
    localparam int EV_SOFT3      = 12;
    localparam int EV_NONE       = 13;

    // soft-event register bit positions.
    localparam int EVENT_RESET_BIT = 15;
    localparam int SCOPE_LSB       = 13;

    // power register, written as a duty and read back as a status word.
    typedef struct packed {
        logic [15:PWM_DUTY_WIDTH] ignored;
        pwm_duty_t                duty;
    } power_wr_t;

    typedef struct packed {
        logic [7:0] zero;
        logic       ign_off;
        logic       power_lost;
        pwm_duty_t  duty;
    } power_rd_t;

    typedef union packed {
        power_wr_t wr;
        power_rd_t rd;
    } power_reg_u;

endpackage

`default_nettype wire

/* reg_bus_if.sv */
`default_nettype none

// flat register bus between the address decoder and the peripherals.
interface reg_bus_if;

    // write data shared by every register.
    logic [15:0] load_data;

    // one-hot strobes, one bit per register address.
    logic [periph_pkg::NUM_REGS-1:0] load;
    logic [periph_pkg::NUM_REGS-1:0] read;

    // readback word per address, each peripheral drives its own entries.
    logic [15:0] rdata [periph_pkg::NUM_REGS];

    modport decoder (
        output load_data,
        output load,
        output read,
        input  rdata
    );

    modport periph (
        input  load_data,
        input  load,
        input  read,
        output rdata
    );

endinterface

`default_nettype wire

/* tick_generator.sv */
`default_nettype none

module tick_generator (
    input  logic sysclk,
    input  logic reset,
    input  logic halt,
    output logic us_tick,
    output logic ms_tick
);

    periph_pkg::us_count_t us_count;
    periph_pkg::ms_count_t ms_count;

    // cascaded dividers, ms counter only advances on us wrap.
    // halt stops the us counter, so both freeze together.
    always_ff @(posedge sysclk) begin
        if (reset) begin
            us_count <= '0;
            ms_count <= '0;
            us_tick  <= 1'b0;
            ms_tick  <= 1'b0;
        end else begin
            us_tick <= 1'b0;
            ms_tick <= 1'b0;
            if (!halt) begin
                if (us_count == periph_pkg::us_count_t'(periph_pkg::SYSCLK_PER_US - 1)) begin
                    us_count <= '0;
                    us_tick  <= 1'b1;
                    // ms pulse lands on the same cycle as its us pulse.
                    if (ms_count == periph_pkg::ms_count_t'(periph_pkg::US_PER_MS - 1)) begin
                        ms_count <= '0;
                        ms_tick  <= 1'b1;
                    end else begin
                        ms_count <= ms_count + 1'b1;
                    end
                end else begin
                    us_count <= us_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bus_decoder.sv */
`default_nettype none

module bus_decoder (
    input  logic                  sysclk,
    input  logic                  reset,
    input  periph_pkg::reg_addr_t reg_addr,
    input  logic                  reg_write,
    input  logic                  reg_read,
    input  logic [15:0]           reg_wdata,
    output logic [15:0]           reg_rdata,
    reg_bus_if.decoder            bus
);

    logic addr_valid;

    // addresses 10 to 15 are unmapped.
    assign addr_valid = (reg_addr < periph_pkg::reg_addr_t'(periph_pkg::NUM_REGS));

    // write data goes to every register, the load strobe picks one.
    assign bus.load_data = reg_wdata;

    // one-hot strobes.
    always_comb begin
        bus.load = '0;
        bus.read = '0;
        if (addr_valid) begin
            bus.load[reg_addr] = reg_write;
            bus.read[reg_addr] = reg_read;
        end
    end

    // readback is combinational from the address.
    // does not depend on reg_read.
    always_comb begin
        reg_rdata = 16'h0000;
        if (addr_valid) begin
            reg_rdata = bus.rdata[reg_addr];
        end
    end

endmodule

`default_nettype wire

/* board_io_regs.sv */
`default_nettype none

module board_io_regs (
    input  logic       sysclk,
    input  logic       reset,
    input  logic [1:0] key,
    input  logic       power_lost,
    input  logic       ignition_switch_off,
    output logic [7:0] leds,
    output logic [3:0] anmux_ctrl,
    output logic [1:0] scope,
    output logic [3:0] soft_events,
    output logic       event_soft_reset,
    output logic       power_lost_sync,
    output logic       ign_off_sync,
    reg_bus_if.periph  bus
);

    logic [6:0]  led_reg;
    logic [3:0]  anmux_reg;
    logic [15:0] soft_event_reg;
    logic        power_lost_meta;
    logic        ign_off_meta;

    // writable registers.
    always_ff @(posedge sysclk) begin
        if (reset) begin
            led_reg        <= '0;
            anmux_reg      <= '0;
            soft_event_reg <= '0;
        end else begin
            if (bus.load[periph_pkg::DR_LEDS]) begin
                led_reg <= bus.load_data[6:0];
            end
            if (bus.load[periph_pkg::DR_ANMUX_CTRL]) begin
                anmux_reg <= bus.load_data[3:0];
            end
            if (bus.load[periph_pkg::DR_SOFT_EVENT]) begin
                soft_event_reg <= bus.load_data;
            end
        end
    end

    // two-flop synchronizers for the off-chip inputs.
    always_ff @(posedge sysclk) begin
        if (reset) begin
            power_lost_meta <= 1'b0;
            power_lost_sync <= 1'b0;
            ign_off_meta    <= 1'b0;
            ign_off_sync    <= 1'b0;
        end else begin
            power_lost_meta <= power_lost;
            power_lost_sync <= power_lost_meta;
            ign_off_meta    <= ignition_switch_off;
            ign_off_sync    <= ign_off_meta;
        end
    end

    // led 7 lights while the ignition is on.
    assign leds       = {~ign_off_sync, led_reg};
    assign anmux_ctrl = anmux_reg;

    // soft-event bits fan out to scope pins, events and controller reset.
    assign scope            = soft_event_reg[periph_pkg::SCOPE_LSB + 1:periph_pkg::SCOPE_LSB];
    assign soft_events      = soft_event_reg[3:0];
    assign event_soft_reset = soft_event_reg[periph_pkg::EVENT_RESET_BIT];

    // readback.
    assign bus.rdata[periph_pkg::DR_LEDS]       = {9'h000, led_reg};
    assign bus.rdata[periph_pkg::SR_KEYS]       = {14'h0000, key};
    assign bus.rdata[periph_pkg::DR_ANMUX_CTRL] = {12'h000, anmux_reg};
    assign bus.rdata[periph_pkg::DR_SOFT_EVENT] = soft_event_reg;

endmodule

`default_nettype wire

/* countdown_timer.sv */
`default_nettype none

module countdown_timer (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        load,
    input  logic        tick,
    input  logic [15:0] data_in,
    output logic [15:0] count,
    output logic        expired
);

    // load wins over a tick on the same cycle.
    // the count sticks at zero until reloaded.
    always_ff @(posedge sysclk) begin
        if (reset) begin
            count <= 16'h0000;
        end else if (load) begin
            count <= data_in;
        end else if (tick && (count != 16'h0000)) begin
            count <= count - 16'd1;
        end
    end

    // level, stays high until the next load.
    assign expired = (count == 16'h0000);

endmodule

`default_nettype wire

/* relay_pwm.sv */
`default_nettype none

module relay_pwm (
    input  logic      sysclk,
    input  logic      reset,
    input  logic      us_tick,
    input  logic      power_lost_sync,
    input  logic      ign_off_sync,
    reg_bus_if.periph bus,
    output logic      pwm_out
);

    periph_pkg::pwm_duty_t  duty;
    periph_pkg::pwm_phase_t phase;
    periph_pkg::power_reg_u wr_view;
    periph_pkg::power_reg_u rd_view;

    // only the duty field of a write is kept.
    assign wr_view = bus.load_data;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            duty <= '0;
        end else if (bus.load[periph_pkg::DR_POWER_DUTY]) begin
            duty <= wr_view.wr.duty;
        end
    end

    // phase counts down once per microsecond, then reloads.
    always_ff @(posedge sysclk) begin
        if (reset) begin
            phase <= periph_pkg::pwm_phase_t'(periph_pkg::PWM_PERIOD - 1);
        end else if (us_tick) begin
            if (phase == '0) begin
                phase <= periph_pkg::pwm_phase_t'(periph_pkg::PWM_PERIOD - 1);
            end else begin
                phase <= phase - 1'b1;
            end
        end
    end

    // registered so the relay pin is glitch free.
    // duty 0 never matches, duty >= period always matches.
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= (int'(phase) < int'(duty));
        end
    end

    // status readback.
    always_comb begin
        rd_view               = '0;
        rd_view.rd.ign_off    = ign_off_sync;
        rd_view.rd.power_lost = power_lost_sync;
        rd_view.rd.duty       = duty;
    end

    assign bus.rdata[periph_pkg::DR_POWER_DUTY] = rd_view;

endmodule

`default_nettype wire

/* event_controller.sv */
`default_nettype none

module event_controller (
    input  logic                             sysclk,
    input  logic                             reset,
    input  logic                             soft_reset,
    input  logic [periph_pkg::NUM_EVENTS-1:0] event_signals,
    reg_bus_if.periph                        bus
);

    logic [periph_pkg::NUM_EVENTS-1:0] enable_mask;
    logic [periph_pkg::NUM_EVENTS-1:0] pending;
    periph_pkg::ev_index_t             next_priority;
    periph_pkg::ev_index_t             ev_priority;

    // enable mask, all events on after either reset.
    always_ff @(posedge sysclk) begin
        if (reset || soft_reset) begin
            enable_mask <= '1;
        end else if (bus.load[periph_pkg::DR_EVENT_ENABLE]) begin
            enable_mask <= bus.load_data[periph_pkg::NUM_EVENTS-1:0];
        end
    end

    assign pending = event_signals & enable_mask;

    // lowest set index wins.
    // scan from the top so the last hit is the most urgent.
    always_comb begin
        next_priority = periph_pkg::ev_index_t'(periph_pkg::EV_NONE);
        for (int i = periph_pkg::NUM_EVENTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                next_priority = periph_pkg::ev_index_t'(i);
            end
        end
    end

    // one cycle from event change to readback.
    // keeps tracking during soft reset, only the mask is forced.
    always_ff @(posedge sysclk) begin
        if (reset) begin
            ev_priority <= periph_pkg::ev_index_t'(periph_pkg::EV_NONE);
        end else begin
            ev_priority <= next_priority;
        end
    end

    // readback.
    assign bus.rdata[periph_pkg::SR_EVENT_PRIORITY] =
        {{(16 - periph_pkg::EV_INDEX_WIDTH){1'b0}}, ev_priority};
    assign bus.rdata[periph_pkg::DR_EVENT_ENABLE] =
        {{(16 - periph_pkg::NUM_EVENTS){1'b0}}, enable_mask};

endmodule

`default_nettype wire

/* io_subsystem_top.sv */
`default_nettype none

module io_subsystem_top (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  halt,
    input  periph_pkg::reg_addr_t reg_addr,
    input  logic                  reg_write,
    input  logic                  reg_read,
    input  logic [15:0]           reg_wdata,
    input  logic [1:0]            key,
    input  logic                  power_lost,
    input  logic                  ignition_switch_off,
    output logic [15:0]           reg_rdata,
    output logic [7:0]            leds,
    output logic [3:0]            anmux_ctrl,
    output logic [1:0]            scope,
    output logic                  power_relay_pwm
);

    logic                              us_tick;
    logic                              ms_tick;
    logic                              power_lost_sync;
    logic                              ign_off_sync;
    logic [3:0]                        soft_events;
    logic                              event_soft_reset;
    logic                              ustimer0_expired;
    logic                              mstimer0_expired;
    logic                              mstimer1_expired;
    logic [periph_pkg::NUM_EVENTS-1:0] event_signals;

    reg_bus_if bus ();

    tick_generator i_ticks (
        .sysclk  (sysclk),
        .reset   (reset),
        .halt    (halt),
        .us_tick (us_tick),
        .ms_tick (ms_tick)
    );

    bus_decoder i_decoder (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_addr  (reg_addr),
        .reg_write (reg_write),
        .reg_read  (reg_read),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .bus       (bus.decoder)
    );

    board_io_regs i_board_io (
        .sysclk              (sysclk),
        .reset               (reset),
        .key                 (key),
        .power_lost          (power_lost),
        .ignition_switch_off (ignition_switch_off),
        .leds                (leds),
        .anmux_ctrl          (anmux_ctrl),
        .scope               (scope),
        .soft_events         (soft_events),
        .event_soft_reset    (event_soft_reset),
        .power_lost_sync     (power_lost_sync),
        .ign_off_sync        (ign_off_sync),
        .bus                 (bus.periph)
    );

    // microsecond timer.
    countdown_timer ustimer0 (
        .sysclk  (sysclk),
        .reset   (reset),
        .load    (bus.load[periph_pkg::DR_USTIMER0]),
        .tick    (us_tick),
        .data_in (bus.load_data),
        .count   (bus.rdata[periph_pkg::DR_USTIMER0]),
        .expired (ustimer0_expired)
    );

    // millisecond timers.
    countdown_timer mstimer0 (
        .sysclk  (sysclk),
        .reset   (reset),
        .load    (bus.load[periph_pkg::DR_MSTIMER0]),
        .tick    (ms_tick),
        .data_in (bus.load_data),
        .count   (bus.rdata[periph_pkg::DR_MSTIMER0]),
        .expired (mstimer0_expired)
    );

    countdown_timer mstimer1 (
        .sysclk  (sysclk),
        .reset   (reset),
        .load    (bus.load[periph_pkg::DR_MSTIMER1]),
        .tick    (ms_tick),
        .data_in (bus.load_data),
        .count   (bus.rdata[periph_pkg::DR_MSTIMER1]),
        .expired (mstimer1_expired)
    );

    relay_pwm i_relay_pwm (
        .sysclk          (sysclk),
        .reset           (reset),
        .us_tick         (us_tick),
        .power_lost_sync (power_lost_sync),
        .ign_off_sync    (ign_off_sync),
        .bus             (bus.periph),
        .pwm_out         (power_relay_pwm)
    );

    // event vector, index 0 is the most urgent.
    // slot 0 is tied low, it would mask everything else.
    assign event_signals[periph_pkg::EV_ZERO]       = 1'b0;
    assign event_signals[periph_pkg::EV_POWER_LOST] = power_lost_sync;
    assign event_signals[periph_pkg::EV_USTIMER0]   = ustimer0_expired;
    assign event_signals[periph_pkg::EV_MSTIMER0]   = mstimer0_expired;
    assign event_signals[periph_pkg::EV_MSTIMER1]   = mstimer1_expired;
    assign event_signals[periph_pkg::EV_KEY0]       = key[0];
    assign event_signals[periph_pkg::EV_KEY1]       = key[1];
    assign event_signals[periph_pkg::EV_IGN_OFF]    = ign_off_sync;
    assign event_signals[periph_pkg::EV_IGN_ON]     = ~ign_off_sync;
    assign event_signals[periph_pkg::EV_SOFT0]      = soft_events[0];
    assign event_signals[periph_pkg::EV_SOFT1]      = soft_events[1];
    assign event_signals[periph_pkg::EV_SOFT2]      = soft_events[2];
    assign event_signals[periph_pkg::EV_SOFT3]      = soft_events[3];

    event_controller i_events (
        .sysclk        (sysclk),
        .reset         (reset),
        .soft_reset    (event_soft_reset),
        .event_signals (event_signals),
        .bus           (bus.periph)
    );

endmodule

`default_nettype wire

/* io_subsystem_asserts.sv */
`default_nettype none

module io_subsystem_asserts (
    input logic                            sysclk,
    input logic                            reset,
    input logic [periph_pkg::NUM_REGS-1:0] load,
    input logic [periph_pkg::NUM_REGS-1:0] read,
    input logic                            us_tick
);

    int assert_failures = 0;

    // one register per strobe at most.
    load_onehot: assert property (@(posedge sysclk) disable iff (reset) $onehot0(load))
        else begin
            assert_failures = assert_failures + 1;
            $error("load strobe not one-hot: %b", load);
        end

    read_onehot: assert property (@(posedge sysclk) disable iff (reset) $onehot0(read))
        else begin
            assert_failures = assert_failures + 1;
            $error("read strobe not one-hot: %b", read);
        end

    // tick pulses are single cycle.
    us_tick_pulse: assert property (@(posedge sysclk) disable iff (reset) us_tick |=> !us_tick)
        else begin
            assert_failures = assert_failures + 1;
            $error("us_tick high on two consecutive cycles");
        end

endmodule

bind bus_decoder io_subsystem_asserts i_bus_asserts (
    .sysclk  (sysclk),
    .reset   (reset),
    .load    (bus.load),
    .read    (bus.read),
    .us_tick (1'b0)
);

bind tick_generator io_subsystem_asserts i_tick_asserts (
    .sysclk  (sysclk),
    .reset   (reset),
    .load    ('0),
    .read    ('0),
    .us_tick (us_tick)
);

`default_nettype wire

/* tb_io_subsystem.sv */
`default_nettype none

module tb_io_subsystem;

    localparam int CLK_PERIOD    = 8;
    localparam int CYCLES_PER_MS = periph_pkg::US_PER_MS * periph_pkg::SYSCLK_PER_US;
    localparam int PWM_CYCLES    = periph_pkg::PWM_PERIOD * periph_pkg::SYSCLK_PER_US;
    // two millisecond timer runs, plus room for the short tests.
    localparam int TIMEOUT_CYCLES = 2 * CYCLES_PER_MS + 20000;

    logic                  sysclk;
    logic                  reset;
    logic                  halt;
    periph_pkg::reg_addr_t reg_addr;
    logic                  reg_write;
    logic                  reg_read;
    logic [15:0]           reg_wdata;
    logic [1:0]            key;
    logic                  power_lost;
    logic                  ignition_switch_off;
    logic [15:0]           reg_rdata;
    logic [7:0]            leds;
    logic [3:0]            anmux_ctrl;
    logic [1:0]            scope;
    logic                  power_relay_pwm;
    integer                seed;
    int                    failed_assertions;

    io_subsystem_top i_dut (
        .sysclk              (sysclk),
        .reset               (reset),
        .halt                (halt),
        .reg_addr            (reg_addr),
        .reg_write           (reg_write),
        .reg_read            (reg_read),
        .reg_wdata           (reg_wdata),
        .key                 (key),
        .power_lost          (power_lost),
        .ignition_switch_off (ignition_switch_off),
        .reg_rdata           (reg_rdata),
        .leds                (leds),
        .anmux_ctrl          (anmux_ctrl),
        .scope               (scope),
        .power_relay_pwm     (power_relay_pwm)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // watchdog.
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge sysclk);
        $display("timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // every wait ends just after a rising edge, where inputs are driven.
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #1;
    endtask

    task automatic wait_ticks(input int n);
        wait_cycles(n * periph_pkg::SYSCLK_PER_US);
    endtask

    task automatic write_reg(input periph_pkg::reg_addr_t addr, input logic [15:0] data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_write = 1'b1;
        @(posedge sysclk);
        #1;
        reg_write = 1'b0;
    endtask

    // readback is combinational, so it is sampled before the strobe edge.
    task automatic read_check(input periph_pkg::reg_addr_t addr, input logic [15:0] expected,
                              input string name);
        reg_addr = addr;
        reg_read = 1'b1;
        #1;
        check_value(name, reg_rdata, expected);
        @(posedge sysclk);
        #1;
        reg_read = 1'b0;
    endtask

    task automatic register_access();
        logic [31:0] rnd;
        logic [6:0]  led_val;
        logic [3:0]  mux_val;
        // reset values, timers at zero and ustimer0 leads the events.
        read_check(periph_pkg::DR_LEDS, 16'h0000, "leds register");
        check_value("leds", {8'h00, leds}, 16'h0080);
        read_check(periph_pkg::SR_KEYS, 16'h0000, "keys");
        read_check(periph_pkg::DR_ANMUX_CTRL, 16'h0000, "anmux register");
        read_check(periph_pkg::DR_USTIMER0, 16'h0000, "ustimer0");
        read_check(periph_pkg::DR_MSTIMER0, 16'h0000, "mstimer0");
        read_check(periph_pkg::DR_MSTIMER1, 16'h0000, "mstimer1");
        read_check(periph_pkg::DR_POWER_DUTY, 16'h0000, "power status");
        read_check(periph_pkg::DR_SOFT_EVENT, 16'h0000, "soft events");
        read_check(periph_pkg::SR_EVENT_PRIORITY, 16'(periph_pkg::EV_USTIMER0), "priority");
        read_check(periph_pkg::DR_EVENT_ENABLE, 16'((1 << periph_pkg::NUM_EVENTS) - 1),
                   "event enable");
        rnd     = $random(seed);
        led_val = rnd[6:0];
        rnd     = $random(seed);
        mux_val = rnd[3:0];
        write_reg(periph_pkg::DR_LEDS, {9'h000, led_val});
        write_reg(periph_pkg::DR_ANMUX_CTRL, {12'h000, mux_val});
        read_check(periph_pkg::DR_LEDS, {9'h000, led_val}, "leds register");
        check_value("leds[6:0]", {9'h000, leds[6:0]}, {9'h000, led_val});
        read_check(periph_pkg::DR_ANMUX_CTRL, {12'h000, mux_val}, "anmux register");
        check_value("anmux_ctrl", {12'h000, anmux_ctrl}, {12'h000, mux_val});
        key = 2'b10;
        read_check(periph_pkg::SR_KEYS, 16'h0002, "keys");
        // read-only address, the write goes nowhere.
        write_reg(periph_pkg::SR_KEYS, 16'hffff);
        read_check(periph_pkg::SR_KEYS, 16'h0002, "keys");
        read_check(periph_pkg::DR_LEDS, {9'h000, led_val}, "leds register");
        key = 2'b00;
    endtask

    task automatic synced_inputs();
        ignition_switch_off = 1'b1;
        wait_cycles(1);
        check_value("leds[7]", {15'h0000, leds[7]}, 16'h0001);
        wait_cycles(1);
        check_value("leds[7]", {15'h0000, leds[7]}, 16'h0000);
        // ignition-off flag is bit 7 of the status word.
        read_check(periph_pkg::DR_POWER_DUTY, 16'h0080, "power status");
        power_lost = 1'b1;
        wait_cycles(2);
        read_check(periph_pkg::DR_POWER_DUTY, 16'h00c0, "power status");
        ignition_switch_off = 1'b0;
        power_lost          = 1'b0;
        wait_cycles(2);
        read_check(periph_pkg::DR_POWER_DUTY, 16'h0000, "power status");
        check_value("leds[7]", {15'h0000, leds[7]}, 16'h0001);
    endtask

    task automatic timers_and_halt();
        // any window of 4 us holds exactly 4 ticks.
        write_reg(periph_pkg::DR_USTIMER0, 16'd5);
        wait_ticks(4);
        read_check(periph_pkg::DR_USTIMER0, 16'd1, "ustimer0");
        wait_ticks(1);
        read_check(periph_pkg::DR_USTIMER0, 16'd0, "ustimer0");
        // let a tick already in flight pass before loading.
        halt = 1'b1;
        wait_cycles(2);
        write_reg(periph_pkg::DR_USTIMER0, 16'd10);
        wait_ticks(3);
        read_check(periph_pkg::DR_USTIMER0, 16'd10, "ustimer0 under halt");
        halt = 1'b0;
        write_reg(periph_pkg::DR_USTIMER0, 16'd0);
        write_reg(periph_pkg::DR_MSTIMER0, 16'd1);
        read_check(periph_pkg::DR_MSTIMER0, 16'd1, "mstimer0");
        wait_ticks(periph_pkg::US_PER_MS);
        read_check(periph_pkg::DR_MSTIMER0, 16'd0, "mstimer0");
    endtask

    task automatic pwm_high_time(input int duty);
        int high_cycles;
        int expected;
        high_cycles = 0;
        if (duty >= periph_pkg::PWM_PERIOD) begin
            expected = PWM_CYCLES;
        end else begin
            expected = duty * periph_pkg::SYSCLK_PER_US;
        end
        write_reg(periph_pkg::DR_POWER_DUTY, 16'(duty));
        read_check(periph_pkg::DR_POWER_DUTY, 16'(duty), "power duty");
        wait_cycles(2);
        // one whole period, each phase lasts one microsecond.
        repeat (PWM_CYCLES) begin
            @(posedge sysclk);
            #1;
            if (power_relay_pwm) begin
                high_cycles++;
            end
        end
        check_value("power_relay_pwm high cycles", 16'(high_cycles), 16'(expected));
    endtask

    task automatic pwm_duty_cycle();
        pwm_high_time(20);
        pwm_high_time(0);
        pwm_high_time(periph_pkg::PWM_PERIOD);
    endtask

    task automatic event_priority();
        logic [15:0] soft_val;
        // soft events only.
        write_reg(periph_pkg::DR_EVENT_ENABLE, 16'(15 << periph_pkg::EV_SOFT0));
        read_check(periph_pkg::DR_EVENT_ENABLE, 16'(15 << periph_pkg::EV_SOFT0), "event enable");
        // scope bit 14 high, bit 13 low.
        soft_val = 16'h4006;
        write_reg(periph_pkg::DR_SOFT_EVENT, soft_val);
        wait_cycles(1);
        read_check(periph_pkg::SR_EVENT_PRIORITY, 16'(periph_pkg::EV_SOFT1), "priority");
        check_value("scope", {14'h0000, scope}, 16'h0002);
        // scope bit 13 high, bit 14 low.
        soft_val = 16'h2000;
        write_reg(periph_pkg::DR_SOFT_EVENT, soft_val);
        wait_cycles(1);
        read_check(periph_pkg::SR_EVENT_PRIORITY, 16'(periph_pkg::EV_NONE), "priority");
        check_value("scope", {14'h0000, scope}, 16'h0001);
        // mstimer1 was never loaded, so it sits expired.
        write_reg(periph_pkg::DR_EVENT_ENABLE, 16'(1 << periph_pkg::EV_MSTIMER1));
        wait_cycles(1);
        read_check(periph_pkg::SR_EVENT_PRIORITY, 16'(periph_pkg::EV_MSTIMER1), "priority");
        // controller reset takes one cycle, the priority one more.
        write_reg(periph_pkg::DR_SOFT_EVENT, 16'(1 << periph_pkg::EVENT_RESET_BIT));
        wait_cycles(2);
        read_check(periph_pkg::DR_EVENT_ENABLE, 16'((1 << periph_pkg::NUM_EVENTS) - 1),
                   "event enable");
        read_check(periph_pkg::SR_EVENT_PRIORITY, 16'(periph_pkg::EV_USTIMER0), "priority");
        check_value("scope", {14'h0000, scope}, 16'h0000);
        write_reg(periph_pkg::DR_SOFT_EVENT, 16'h0000);
    endtask

    initial begin
        seed                = 63;
        reset               = 1'b1;
        halt                = 1'b0;
        reg_addr            = '0;
        reg_write           = 1'b0;
        reg_read            = 1'b0;
        reg_wdata           = 16'h0000;
        key                 = 2'b00;
        power_lost          = 1'b0;
        ignition_switch_off = 1'b0;
        repeat (5) @(posedge sysclk);
        #1;
        reset = 1'b0;
        // priority register needs one cycle out of reset.
        wait_cycles(2);
        register_access();
        synced_inputs();
        timers_and_halt();
        pwm_duty_cycle();
        event_priority();
        failed_assertions = i_dut.i_decoder.i_bus_asserts.assert_failures
                          + i_dut.i_ticks.i_tick_asserts.assert_failures;
        if (failed_assertions == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", failed_assertions);
            $display("Regression failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* tb.f */
periph_pkg.sv
reg_bus_if.sv
tick_generator.sv
bus_decoder.sv
board_io_regs.sv
countdown_timer.sv
relay_pwm.sv
event_controller.sv
io_subsystem_top.sv
io_subsystem_asserts.sv
tb_io_subsystem.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail.
rm -f sim.log
verilator --binary --timing --assert --top-module tb_io_subsystem -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log && exit 0 || exit 1
